// ==== list.f ====
common/dmc_clk_pkg.sv
common/dmc_apb_pkg.sv
rtl/dmc_cfg_regs.sv
rtl/dmc_dqs_dly_line.sv
rtl/dmc_clk_downsample.sv
rtl/dmc_reset_sync.sv
rtl/dmc_clk_rst_gen.sv
test/dmc_clk_rst_gen_tb.sv

// ==== Bender.yml ====
package:
  name: dmc_clk_rst_gen

sources:
  # packages first, the register package uses the clock package
  - common/dmc_clk_pkg.sv
  - common/dmc_apb_pkg.sv
  - rtl/dmc_cfg_regs.sv
  - rtl/dmc_dqs_dly_line.sv
  - rtl/dmc_clk_downsample.sv
  - rtl/dmc_reset_sync.sv
  - rtl/dmc_clk_rst_gen.sv
  - target: test
    files:
      - test/dmc_clk_rst_gen_tb.sv

// ==== test/dmc_clk_rst_gen_tb.sv ====
`timescale 1ns/100ps

module dmc_clk_rst_gen_tb;

  localparam int tsw = dmc_clk_pkg::tap_sel_width;
  localparam int groups = dmc_clk_pkg::dq_groups;
  // what the comparing process looks at
  localparam int mode_idle = 0;
  localparam int mode_dly_reset = 1;
  localparam int mode_dly_track = 2;
  localparam int mode_ds_hold = 3;
  localparam int mode_ds_run = 4;
  localparam int mode_rst_sync = 5;
  // test lengths in cycles that also size the watchdog
  localparam int reg_cycles = 80;
  localparam int dly_rst_cycles = 20;
  localparam int dly_cycles = 200;
  localparam int ds_hold_cycles = 10;
  localparam int ds_run_cycles = 40;
  localparam int sync_toggles = 8;
  localparam int total_cycles = reg_cycles + dly_rst_cycles + dly_cycles + 40 +
    4 * (ds_hold_cycles + ds_run_cycles + 12) + sync_toggles * 18 + 40;
  localparam int watchdog_ns = total_cycles * 4 + 1000;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic [dmc_apb_pkg::apb_addr_width-1:0] paddr = '0;
  logic psel = 1'b0;
  logic penable = 1'b0;
  logic pwrite = 1'b0;
  logic [dmc_apb_pkg::apb_data_width-1:0] pwdata = '0;
  logic [dmc_apb_pkg::apb_data_width-1:0] prdata;
  logic pready;
  logic pslverr;
  logic async_reset = 1'b1;
  logic [groups-1:0] dqs_clk_i = '0;
  logic [groups-1:0] dqs_clk_o;
  logic ui_reset;
  logic dfi_reset;
  logic dfi_clk_2x;
  logic dfi_clk_1x;

  // reference state
  logic [31:0] shadow [3];
  logic [7:0] dqs_hist [groups];
  logic [1:0] ui_hist = 2'b11;
  logic [1:0] dfi_hist = 2'b11;
  logic [dmc_clk_pkg::ds_width-1:0] ds_val_cur;
  logic last_1x = 1'b0;
  int check_mode = mode_idle;
  int ds_toggles;
  int run_len;
  int dfi_edges;
  logic [31:0] rng_state = 32'd65;
  string cur_test = "";
  int test_errs;
  int tests_run;
  int tests_failed;

  // one clock drives ui and 2x so config crossings line up exactly
  always #2 clk = ~clk;

  dmc_clk_rst_gen dmc_clk_rst_gen_inst (
    .ui_clk_i(clk), .reset_i(reset),
    .paddr_i(paddr), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
    .ext_dfi_clk_2x_i(clk), .async_reset_i(async_reset),
    .dqs_clk_i(dqs_clk_i), .dqs_clk_o(dqs_clk_o),
    .ui_reset_o(ui_reset), .dfi_reset_o(dfi_reset),
    .dfi_clk_2x_o(dfi_clk_2x), .dfi_clk_1x_o(dfi_clk_1x)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] rand_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // register index by offset or -1 when unmapped
  function automatic int reg_index(input logic [3:0] addr);
    case (addr)
      dmc_apb_pkg::reg_dly_ctrl_addr: return 0;
      dmc_apb_pkg::reg_dly_taps_addr: return 1;
      dmc_apb_pkg::reg_ds_ctrl_addr: return 2;
      default: return -1;
    endcase
  endfunction

  // implemented bits per register
  function automatic logic [31:0] reg_mask(input int idx);
    if (idx == 0) return 32'h1;
    if (idx == 1) return (32'h1 << (groups * tsw)) - 1;
    return (32'h1 << (dmc_clk_pkg::ds_width + 1)) - 1;
  endfunction

  function automatic logic [31:0] exp_reg(input logic [3:0] addr);
    if (reg_index(addr) < 0) return 32'h0;
    return shadow[reg_index(addr)];
  endfunction

  function automatic logic [tsw-1:0] exp_tap(input int g);
    return shadow[1][g*tsw +: tsw];
  endfunction

  // history slot 0 is the value sampled at the last edge
  function automatic logic exp_dqs(input int g, input int tap);
    return dqs_hist[g][tap+1];
  endfunction

  function automatic int exp_phase_len(input logic [dmc_clk_pkg::ds_width-1:0] val);
    return int'(val) + 1;
  endfunction

  task automatic report_mismatch(input logic [31:0] expected, input logic [31:0] actual);
    $display("Error %s: expected %0h, actual %0h", cur_test, expected, actual);
    test_errs++;
  endtask

  task automatic report_failure(input string msg);
    $display("%s: %s", cur_test, msg);
    test_errs++;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errs == 0) begin
      $display("test %s passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic drive_dqs(input int n);
    logic [31:0] r;
    repeat (n) begin
      r = rand_word();
      dqs_clk_i = r[groups-1:0];
      @(posedge clk);
      #1;
    end
  endtask

  // setup phase then access phase with a bounded wait on pready
  task automatic apb_transfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
    int waited;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    waited = 0;
    @(negedge clk);
    while (pready !== 1'b1 && waited < 16) begin
      @(negedge clk);
      waited++;
    end
    if (pready !== 1'b1) report_failure("APB access got no pready within 16 cycles");
    rdata = prdata;
    err = pslverr;
    @(posedge clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic err;
    int idx;
    idx = reg_index(addr);
    apb_transfer(1'b1, addr, data, rdata, err);
    if (idx < 0 && err !== 1'b1) report_failure("write to unmapped offset gave no pslverr");
    if (idx >= 0 && err !== 1'b0) report_failure("write to mapped offset raised pslverr");
    if (idx >= 0) shadow[idx] = data & reg_mask(idx);
  endtask

  task automatic read_check(input logic [3:0] addr);
    logic [31:0] rdata;
    logic err;
    apb_transfer(1'b0, addr, 32'h0, rdata, err);
    if (reg_index(addr) < 0 && err !== 1'b1) begin
      report_failure("read of unmapped offset gave no pslverr");
    end
    if (reg_index(addr) >= 0 && err !== 1'b0) begin
      report_failure("read of mapped offset raised pslverr");
    end
    if (rdata !== exp_reg(addr)) report_mismatch(exp_reg(addr), rdata);
  endtask

  // pass-through checked just after every clock edge
  always @(clk) begin
    #0.5;
    if (dfi_clk_2x !== clk) report_mismatch(32'(clk), 32'(dfi_clk_2x));
  end

  // dfi domain sampling counted on the 1x clock itself
  always @(posedge dfi_clk_1x) begin
    dfi_hist = {dfi_hist[0], async_reset};
    dfi_edges++;
  end

  // mid-cycle compare while outputs are settled and inputs stable
  always @(negedge clk) begin : compare_outputs
    int g;
    if (check_mode == mode_dly_reset && dqs_clk_o !== '0) begin
      report_mismatch(32'h0, 32'(dqs_clk_o));
    end
    if (check_mode == mode_dly_track) begin
      for (g = 0; g < groups; g++) begin
        if (dqs_clk_o[g] !== exp_dqs(g, exp_tap(g))) begin
          report_mismatch(32'(exp_dqs(g, exp_tap(g))), 32'(dqs_clk_o[g]));
        end
      end
    end
    if (check_mode == mode_ds_hold && dfi_clk_1x !== 1'b0) begin
      report_mismatch(32'h0, 32'(dfi_clk_1x));
    end
    if (check_mode == mode_ds_run) begin
      if (dfi_clk_1x !== last_1x) begin
        // first phase after release is partial
        if (ds_toggles > 0 && run_len != exp_phase_len(ds_val_cur)) begin
          report_mismatch(exp_phase_len(ds_val_cur), run_len);
        end
        ds_toggles++;
        run_len = 1;
      end else begin
        run_len++;
      end
    end
    if (check_mode == mode_rst_sync) begin
      if (ui_reset !== ui_hist[1]) report_mismatch(32'(ui_hist[1]), 32'(ui_reset));
      if (dfi_reset !== dfi_hist[1]) report_mismatch(32'(dfi_hist[1]), 32'(dfi_reset));
    end
    // histories move on after the compare
    for (g = 0; g < groups; g++) dqs_hist[g] = {dqs_hist[g][6:0], dqs_clk_i[g]};
    ui_hist = {ui_hist[0], async_reset};
    last_1x = dfi_clk_1x;
  end

  initial begin : watchdog
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin : run_tests
    int i;
    int k;
    int edges_before;
    logic [31:0] r;
    logic [3:0] addrs [3];
    addrs[0] = dmc_apb_pkg::reg_dly_ctrl_addr;
    addrs[1] = dmc_apb_pkg::reg_dly_taps_addr;
    addrs[2] = dmc_apb_pkg::reg_ds_ctrl_addr;
    shadow[0] = dmc_apb_pkg::dly_ctrl_reset_val;
    shadow[1] = dmc_apb_pkg::dly_taps_reset_val;
    shadow[2] = dmc_apb_pkg::ds_ctrl_reset_val;
    for (i = 0; i < groups; i++) dqs_hist[i] = '0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // reset values, random readback, unmapped offset
    cur_test = "reg_block";
    for (i = 0; i < 3; i++) read_check(addrs[i]);
    for (i = 0; i < 3; i++) begin
      for (k = 0; k < 3; k++) begin
        r = rand_word();
        write_reg(addrs[i], r & reg_mask(i));
        read_check(addrs[i]);
      end
    end
    r = rand_word();
    write_reg(4'hc, r);
    read_check(4'hc);
    for (i = 0; i < 3; i++) read_check(addrs[i]);
    finish_test();

    cur_test = "dly_in_reset";
    write_reg(dmc_apb_pkg::reg_dly_ctrl_addr, 32'h1);
    idle(2);
    check_mode = mode_dly_reset;
    drive_dqs(dly_rst_cycles);
    check_mode = mode_idle;
    finish_test();

    // taps change only while the lines sit in reset
    cur_test = "dly_per_group";
    r = rand_word();
    write_reg(dmc_apb_pkg::reg_dly_taps_addr, r & reg_mask(1));
    write_reg(dmc_apb_pkg::reg_dly_ctrl_addr, 32'h0);
    drive_dqs(2 * dmc_clk_pkg::num_taps);
    check_mode = mode_dly_track;
    drive_dqs(dly_cycles);
    check_mode = mode_idle;
    finish_test();

    cur_test = "downsampler";
    for (i = 0; i < 4; i++) begin
      ds_val_cur = i[dmc_clk_pkg::ds_width-1:0];
      write_reg(dmc_apb_pkg::reg_ds_ctrl_addr, (32'h1 << dmc_clk_pkg::ds_width) | i);
      idle(2);
      check_mode = mode_ds_hold;
      idle(ds_hold_cycles);
      check_mode = mode_idle;
      write_reg(dmc_apb_pkg::reg_ds_ctrl_addr, i);
      ds_toggles = 0;
      run_len = 0;
      check_mode = mode_ds_run;
      idle(ds_run_cycles);
      check_mode = mode_idle;
      if (ds_toggles < 4) report_failure("1x clock toggled too few times after release");
    end
    finish_test();

    // 1x clock at period 4 so each hold spans two 1x edges
    cur_test = "reset_sync";
    write_reg(dmc_apb_pkg::reg_ds_ctrl_addr, (32'h1 << dmc_clk_pkg::ds_width) | 1);
    write_reg(dmc_apb_pkg::reg_ds_ctrl_addr, 32'h1);
    idle(12);
    edges_before = dfi_edges;
    check_mode = mode_rst_sync;
    for (i = 0; i < sync_toggles; i++) begin
      async_reset = ~async_reset;
      r = rand_word();
      idle(10 + int'(r[2:0]));
    end
    check_mode = mode_idle;
    if (dfi_edges - edges_before < 2 * sync_toggles) begin
      report_failure("1x clock gave too few rising edges for the dfi synchronizer");
    end
    finish_test();

    $display("%0d tests run, %0d passed, %0d failed", tests_run, tests_run - tests_failed,
             tests_failed);
    if (tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== rtl/dmc_clk_rst_gen.sv ====
`timescale 1ns/100ps

module dmc_clk_rst_gen (
  input  logic                                   ui_clk_i,
  input  logic                                   reset_i,
  // configuration over apb
  input  logic [dmc_apb_pkg::apb_addr_width-1:0] paddr_i,
  input  logic                                   psel_i,
  input  logic                                   penable_i,
  input  logic                                   pwrite_i,
  input  logic [dmc_apb_pkg::apb_data_width-1:0] pwdata_i,
  output logic [dmc_apb_pkg::apb_data_width-1:0] prdata_o,
  output logic                                   pready_o,
  output logic                                   pslverr_o,
  // 2x clock from the external generator
  input  logic                                   ext_dfi_clk_2x_i,
  // controller reset, asynchronous
  input  logic                                   async_reset_i,
  // dqs strobes in and delayed out
  input  logic [dmc_clk_pkg::dq_groups-1:0]      dqs_clk_i,
  output logic [dmc_clk_pkg::dq_groups-1:0]      dqs_clk_o,
  output logic                                   ui_reset_o,
  output logic                                   dfi_reset_o,
  output logic                                   dfi_clk_2x_o,
  output logic                                   dfi_clk_1x_o
);

  // quasi static controls from the register block
  logic                                                          dly_reset;
  logic [dmc_clk_pkg::dq_groups*dmc_clk_pkg::tap_sel_width-1:0] tap_sel;
  logic                                                          ds_reset;
  logic [dmc_clk_pkg::ds_width-1:0]                              ds_val;

  genvar g;

  dmc_cfg_regs cfg_regs_inst (
    .ui_clk_i    (ui_clk_i),
    .reset_i     (reset_i),
    .paddr_i     (paddr_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .dly_reset_o (dly_reset),
    .tap_sel_o   (tap_sel),
    .ds_reset_o  (ds_reset),
    .ds_val_o    (ds_val)
  );

  // external 2x clock used directly, no on-chip oscillator
  assign dfi_clk_2x_o = ext_dfi_clk_2x_i;

  // one delay line per dq group, each with its own tap slice
  for (g = 0; g < dmc_clk_pkg::dq_groups; g++) begin : dly_lines
    dmc_dqs_dly_line dly_line_inst (
      .clk_i       (dfi_clk_2x_o),
      .dly_reset_i (dly_reset),
      .tap_sel_i   (tap_sel[g*dmc_clk_pkg::tap_sel_width +: dmc_clk_pkg::tap_sel_width]),
      .dqs_i       (dqs_clk_i[g]),
      .dqs_o       (dqs_clk_o[g])
    );
  end

  // 1x clock, can be parked in reset to save power
  dmc_clk_downsample clk_ds_inst (
    .clk_i      (dfi_clk_2x_o),
    .ds_reset_i (ds_reset),
    .ds_val_i   (ds_val),
    .clk_o      (dfi_clk_1x_o)
  );

  // controller reset into the ui domain
  dmc_reset_sync ui_reset_inst (
    .clk_i   (ui_clk_i),
    .reset_i (async_reset_i),
    .reset_o (ui_reset_o)
  );

  // and into the 1x dfi domain
  dmc_reset_sync dfi_reset_inst (
    .clk_i   (dfi_clk_1x_o),
    .reset_i (async_reset_i),
    .reset_o (dfi_reset_o)
  );

endmodule

// ==== rtl/dmc_reset_sync.sv ====
`timescale 1ns/100ps

module dmc_reset_sync (
  input  logic clk_i,
  input  logic reset_i,
  output logic reset_o
);

  // two stage synchronizer
  // starts at 1 so the domain powers up in reset
  logic [1:0] sync_r = 2'b11;

  always_ff @(posedge clk_i) begin
    sync_r <= {sync_r[0], reset_i};
  end

  assign reset_o = sync_r[1];

  // output is the input two edges late, no more, no less
  rst_two_stage: assert property (@(posedge clk_i)
    1'b1 |-> ##2 (reset_o == $past(reset_i, 2)));

endmodule

// ==== rtl/dmc_clk_downsample.sv ====
`timescale 1ns/100ps

module dmc_clk_downsample (
  input  logic                            clk_i,
  input  logic                            ds_reset_i,
  input  logic [dmc_clk_pkg::ds_width-1:0] ds_val_i,
  output logic                            clk_o
);

  // phase counter, 0 up to ds_val_i
  logic [dmc_clk_pkg::ds_width-1:0] cnt_r;
  logic                             wrap;
  logic                             clk_r;

  assign wrap = (cnt_r == ds_val_i);

  // held low and idle to save power while in reset
  always_ff @(posedge clk_i) begin
    if (ds_reset_i) begin
      cnt_r <= '0;
      clk_r <= 1'b0;
    end else if (wrap) begin
      // phase done, flip the 1x clock and restart
      cnt_r <= '0;
      clk_r <= ~clk_r;
    end else begin
      cnt_r <= cnt_r + 1'b1;
    end
  end

  // registered so the 1x clock is glitch free
  assign clk_o = clk_r;

  // a phase only ends on a wrap or when reset pulls it low
  ds_toggle_on_wrap: assert property (@(posedge clk_i)
    (clk_r != $past(clk_r)) |-> ($past(wrap) || $past(ds_reset_i)));

endmodule

// ==== rtl/dmc_dqs_dly_line.sv ====
`timescale 1ns/100ps

module dmc_dqs_dly_line (
  input  logic                                 clk_i,
  input  logic                                 dly_reset_i,
  input  logic [dmc_clk_pkg::tap_sel_width-1:0] tap_sel_i,
  input  logic                                 dqs_i,
  output logic                                 dqs_o
);

  // tap chain where stage k holds dqs_i from k+1 edges back
  logic [dmc_clk_pkg::num_taps-1:0] chain_r;
  logic                             dqs_r;

  always_ff @(posedge clk_i) begin
    if (dly_reset_i) begin
      chain_r <= '0;
    end else begin
      chain_r <= {chain_r[dmc_clk_pkg::num_taps-2:0], dqs_i};
    end
  end

  // output stage adds one cycle
  // so tap n gives n+1 cycles overall
  always_ff @(posedge clk_i) begin
    if (dly_reset_i) begin
      dqs_r <= 1'b0;
    end else begin
      dqs_r <= chain_r[tap_sel_i];
    end
  end

  assign dqs_o = dqs_r;

  // cleared output and cleared chain keep the line quiet two cycles
  dly_quiet_after_reset: assert property (@(posedge clk_i)
    dly_reset_i |=> !dqs_o ##1 !dqs_o);

endmodule

// ==== rtl/dmc_cfg_regs.sv ====
`timescale 1ns/100ps

module dmc_cfg_regs (
  input  logic                                   ui_clk_i,
  input  logic                                   reset_i,
  // apb slave
  input  logic [dmc_apb_pkg::apb_addr_width-1:0] paddr_i,
  input  logic                                   psel_i,
  input  logic                                   penable_i,
  input  logic                                   pwrite_i,
  input  logic [dmc_apb_pkg::apb_data_width-1:0] pwdata_i,
  output logic [dmc_apb_pkg::apb_data_width-1:0] prdata_o,
  output logic                                   pready_o,
  output logic                                   pslverr_o,
  // clock generation controls
  output logic                                   dly_reset_o,
  output logic [dmc_clk_pkg::dq_groups*dmc_clk_pkg::tap_sel_width-1:0] tap_sel_o,
  output logic                                   ds_reset_o,
  output logic [dmc_clk_pkg::ds_width-1:0]       ds_val_o
);

  // access phase and address decode
  logic access;
  logic hit_dly_ctrl;
  logic hit_dly_taps;
  logic hit_ds_ctrl;
  logic mapped;

  // control registers store only implemented bits
  logic                                                          dly_ctrl_r;
  logic [dmc_clk_pkg::dq_groups*dmc_clk_pkg::tap_sel_width-1:0] dly_taps_r;
  logic [dmc_clk_pkg::ds_width:0]                                ds_ctrl_r;

  assign access       = psel_i && penable_i;
  assign hit_dly_ctrl = (paddr_i == dmc_apb_pkg::reg_dly_ctrl_addr);
  assign hit_dly_taps = (paddr_i == dmc_apb_pkg::reg_dly_taps_addr);
  assign hit_ds_ctrl  = (paddr_i == dmc_apb_pkg::reg_ds_ctrl_addr);
  assign mapped       = hit_dly_ctrl || hit_dly_taps || hit_ds_ctrl;

  // no wait states
  assign pready_o  = access;
  // unmapped offset flagged only in the access phase
  assign pslverr_o = access && !mapped;

  // write lands on the edge that closes the access phase
  always_ff @(posedge ui_clk_i) begin
    if (reset_i) begin
      dly_ctrl_r <= dmc_apb_pkg::dly_ctrl_reset_val[0];
      dly_taps_r <= dmc_apb_pkg::dly_taps_reset_val[$bits(dly_taps_r)-1:0];
      ds_ctrl_r  <= dmc_apb_pkg::ds_ctrl_reset_val[dmc_clk_pkg::ds_width:0];
    end else if (access && pwrite_i) begin
      // unmapped writes fall through untouched
      if (hit_dly_ctrl) begin
        dly_ctrl_r <= pwdata_i[0];
      end
      if (hit_dly_taps) begin
        dly_taps_r <= pwdata_i[$bits(dly_taps_r)-1:0];
      end
      if (hit_ds_ctrl) begin
        ds_ctrl_r <= pwdata_i[dmc_clk_pkg::ds_width:0];
      end
    end
  end

  // zero extended read mux with unmapped reads as 0
  always_comb begin
    prdata_o = '0;
    case (paddr_i)
      dmc_apb_pkg::reg_dly_ctrl_addr: prdata_o[0] = dly_ctrl_r;
      dmc_apb_pkg::reg_dly_taps_addr: prdata_o[$bits(dly_taps_r)-1:0] = dly_taps_r;
      dmc_apb_pkg::reg_ds_ctrl_addr:  prdata_o[dmc_clk_pkg::ds_width:0] = ds_ctrl_r;
      default:                        prdata_o = '0;
    endcase
  end

  // fields out to the clock blocks
  assign dly_reset_o = dly_ctrl_r;
  assign tap_sel_o   = dly_taps_r;
  assign ds_val_o    = ds_ctrl_r[dmc_clk_pkg::ds_width-1:0];
  assign ds_reset_o  = ds_ctrl_r[dmc_clk_pkg::ds_width];

  // host must open every transfer with a setup phase
  apb_enable_in_sel: assert property (@(posedge ui_clk_i) disable iff (reset_i)
    penable_i |-> psel_i);

  // error response only in an access phase that follows its setup phase
  apb_err_in_access: assert property (@(posedge ui_clk_i) disable iff (reset_i)
    pslverr_o |-> $past(psel_i && !penable_i));

endmodule

// ==== common/dmc_apb_pkg.sv ====
package dmc_apb_pkg;

  // apb bus geometry
  localparam int apb_addr_width = 4;
  localparam int apb_data_width = 32;

  // register map, byte offsets

  // bit 0 holds all dqs delay lines in reset
  localparam logic [apb_addr_width-1:0] reg_dly_ctrl_addr = 4'h0;
  // tap select per group, group 0 in the low bits
  localparam logic [apb_addr_width-1:0] reg_dly_taps_addr = 4'h4;
  // downsample value in the low bits, downsampler reset just above
  localparam logic [apb_addr_width-1:0] reg_ds_ctrl_addr  = 4'h8;

  // reset values
  // delay lines come up held in reset
  localparam logic [apb_data_width-1:0] dly_ctrl_reset_val = 32'h1;
  localparam logic [apb_data_width-1:0] dly_taps_reset_val = 32'h0;
  // downsampler held off, value 0
  localparam logic [apb_data_width-1:0] ds_ctrl_reset_val =
    apb_data_width'(1) << dmc_clk_pkg::ds_width;

endpackage

// ==== common/dmc_clk_pkg.sv ====
package dmc_clk_pkg;

  // dq groups, one dqs strobe each
  localparam int dq_groups = 4;

  // delay line depth in 2x clock cycles
  localparam int num_taps = 4;

  // tap select, enough bits to address every tap
  localparam int tap_sel_width = 2;

  // downsample value width
  // 1x clock phase lasts val+1 cycles of the 2x clock
  localparam int ds_width = 2;

endpackage
